//--- build.f
+incdir+tb
rtl/mul_cfg_pkg.sv
rtl/mul_types_pkg.sv
rtl/mul_issue_if.sv
rtl/mul_booth_sel.sv
rtl/mul_csa_layer.sv
rtl/mul_csa_tree.sv
rtl/mul_booth_stage.sv
rtl/mul_result_stage.sv
rtl/mul_top.sv
tb/tb_mul.sv

//--- rtl/mul_booth_sel.sv
// Booth row select: one radix-4 digit picks 0, +-1 or +-2 times the multiplicand.
`timescale 1ns/1ps
`default_nettype none

module mul_booth_sel
	import mul_cfg_pkg::*, mul_types_pkg::*;
#(
	parameter int POSITION = 0
) (
	input  logic [2:0] digit,
	input  opnd_t      mcand,
	output prod_t      row,
	output logic       neg
);

	prod_t mcand_ext;
	prod_t mag;
	logic  one;
	logic  two;

	assign mcand_ext = {{(PROD_W-OPND_W){mcand[OPND_W-1]}}, mcand};

	assign one = digit[1] ^ digit[0];
	assign two = (digit == 3'b011) | (digit == 3'b100);
	assign neg = digit[2] & ~(digit[1] & digit[0]); // 3'b111 is minus zero.

	always_comb begin
		if (one)
			mag = mcand_ext;
		else if (two)
			mag = mcand_ext << 1;
		else
			mag = '0;
	end

	// ones complement here, the missing +1 comes in through the negation row.
	assign row = (neg ? ~mag : mag) << (2 * POSITION);

	// a negated row must also select a nonzero multiple.
	always_comb begin
		a_neg_zero: assert final (!neg || one || two)
			else $error("negation flag set for a zero digit.");
	end

endmodule

`default_nettype wire

//--- rtl/mul_booth_stage.sv
// Booth stage: extends both operands, encodes the multiplier and registers the rows.
`timescale 1ns/1ps
`default_nettype none

module mul_booth_stage
	import mul_cfg_pkg::*, mul_types_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       flush,
	mul_issue_if.dst   issue,
	input  logic       stage2_valid,
	output row_array_t rows,
	output logic       stage1_valid
);

	opnd_t               mcand;
	opnd_t               mplier;
	logic [OPND_W:0]     mplier_pad;
	prod_t               pp [N_DIGITS];
	logic [N_DIGITS-1:0] neg;
	prod_t               neg_row;
	logic                accept;

	// upper bits follow the sign field, word mode takes bit 31 as the sign.
	function automatic opnd_t extend(input xlen_t value, input logic word, input logic is_signed);
		logic sign_bit;
		sign_bit = is_signed & (word ? value[WORD_W-1] : value[XLEN-1]);
		if (word)
			return {{(OPND_W-WORD_W){sign_bit}}, value[WORD_W-1:0]};
		return {{(OPND_W-XLEN){sign_bit}}, value};
	endfunction

	assign mcand      = extend(issue.multiplicand, issue.mulw, issue.sign.a_signed);
	assign mplier     = extend(issue.multiplier, issue.mulw, issue.sign.b_signed);
	assign mplier_pad = {mplier, 1'b0}; // implicit zero below bit 0.

	for (genvar i = 0; i < N_DIGITS; i++) begin : g_digit
		mul_booth_sel #(.POSITION(i)) i_sel (
			.digit (mplier_pad[2*i +: 3]),
			.mcand (mcand),
			.row   (pp[i]),
			.neg   (neg[i])
		);
	end

	// the +1 of each inverted row, placed at that row's lowest bit.
	always_comb begin
		neg_row = '0;
		for (int i = 0; i < N_DIGITS; i++)
			neg_row[2*i] = neg[i];
	end

	assign accept      = issue.valid & issue.ready;
	assign issue.ready = ~(stage1_valid | stage2_valid);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stage1_valid <= 1'b0;
			rows         <= '{default: '0};
		end else begin
			stage1_valid <= accept & ~flush;
			if (accept) begin
				for (int i = 0; i < N_DIGITS; i++)
					rows[i] <= pp[i];
				rows[N_DIGITS] <= neg_row;
			end
		end
	end

	// an operation kept in stage one blocks issue until it has left stage two.
	a_single_issue: assert property (
		@(posedge clk) disable iff (!arst_n)
		accept && !flush |=> !accept ##1 (!accept || $past(flush))
	) else $error("operation accepted while the pipeline is busy.");

endmodule

`default_nettype wire

//--- rtl/mul_cfg_pkg.sv
// Multiplier sizes: operand, extended operand and product widths, Booth row counts.
`default_nettype none

package mul_cfg_pkg;

	localparam int XLEN     = 64;
	localparam int WORD_W   = 32;            // word mode uses the low half only.
	localparam int OPND_W   = XLEN + 2;      // room for the sign of an unsigned operand.
	localparam int PROD_W   = 2 * OPND_W;
	localparam int N_DIGITS = OPND_W / 2;    // one radix-4 digit per two multiplier bits.
	localparam int N_ROWS   = N_DIGITS + 1;  // plus the row of negation bits.

	// 3:2 levels needed to bring N_ROWS down to a sum and a carry.
	localparam int CSA_LEVELS = 8;

	// each full group of three rows leaves two, the rest pass through.
	function automatic int rows_after_level(input int n_in);
		return (n_in / 3) * 2 + n_in % 3;
	endfunction

endpackage

`default_nettype wire

//--- rtl/mul_csa_layer.sv
// One carry-save level: full adders over groups of three rows, the rest passed on.
`timescale 1ns/1ps
`default_nettype none

module mul_csa_layer
	import mul_cfg_pkg::*, mul_types_pkg::*;
#(
	parameter  int N_IN  = 3,
	localparam int N_OUT = rows_after_level(N_IN)
) (
	input  prod_t rows_in  [N_IN],
	output prod_t rows_out [N_OUT]
);

	localparam int N_GROUPS = N_IN / 3;
	localparam int N_PASS   = N_IN % 3;

	for (genvar g = 0; g < N_GROUPS; g++) begin : g_fa
		prod_t a;
		prod_t b;
		prod_t c;

		assign a = rows_in[3*g];
		assign b = rows_in[3*g+1];
		assign c = rows_in[3*g+2];

		assign rows_out[2*g]   = a ^ b ^ c;
		assign rows_out[2*g+1] = ((a & b) | (a & c) | (b & c)) << 1; // carry weighs one up.
	end

	for (genvar p = 0; p < N_PASS; p++) begin : g_pass
		assign rows_out[2*N_GROUPS+p] = rows_in[3*N_GROUPS+p];
	end

endmodule

`default_nettype wire

//--- rtl/mul_csa_tree.sv
// Carry-save tree: reduces the partial product rows to one sum and one carry.
`timescale 1ns/1ps
`default_nettype none

module mul_csa_tree
	import mul_cfg_pkg::*, mul_types_pkg::*;
(
	input  row_array_t rows,
	input  logic       in_valid,
	output prod_t      sum,
	output prod_t      carry
);

	// row count entering a given level.
	function automatic int rows_at_level(input int level);
		int n;
		n = N_ROWS;
		for (int l = 0; l < level; l++)
			n = rows_after_level(n);
		return n;
	endfunction

	for (genvar l = 0; l < CSA_LEVELS; l++) begin : g_level
		localparam int N_IN  = rows_at_level(l);
		localparam int N_OUT = rows_after_level(N_IN);

		prod_t lvl_in  [N_IN];
		prod_t lvl_out [N_OUT];

		if (l == 0) begin : g_first
			assign lvl_in = rows;
		end else begin : g_next
			assign lvl_in = g_level[l-1].lvl_out;
		end

		mul_csa_layer #(.N_IN(N_IN)) i_layer (
			.rows_in  (lvl_in),
			.rows_out (lvl_out)
		);
	end

	// an empty stage one hands zeros to stage two.
	assign sum   = in_valid ? g_level[CSA_LEVELS-1].lvl_out[0] : '0;
	assign carry = in_valid ? g_level[CSA_LEVELS-1].lvl_out[1] : '0;

endmodule

`default_nettype wire

//--- rtl/mul_issue_if.sv
// Issue channel carrying one operation from the top level into the Booth stage.
`timescale 1ns/1ps
`default_nettype none

interface mul_issue_if;

	logic                      valid;
	logic                      ready;
	logic                      mulw;          // multiply the low words only.
	mul_types_pkg::sign_mode_t sign;
	mul_types_pkg::xlen_t      multiplicand;
	mul_types_pkg::xlen_t      multiplier;

	modport src (
		output valid, mulw, sign, multiplicand, multiplier,
		input  ready
	);

	modport dst (
		input  valid, mulw, sign, multiplicand, multiplier,
		output ready
	);

endinterface

`default_nettype wire

//--- rtl/mul_result_stage.sv
// Result stage: holds the tree sum and carry, adds them and splits the product.
`timescale 1ns/1ps
`default_nettype none

module mul_result_stage
	import mul_cfg_pkg::*, mul_types_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  flush,
	input  logic  in_valid,
	input  prod_t sum,
	input  prod_t carry,
	output logic  out_valid,
	output xlen_t result_hi,
	output xlen_t result_lo
);

	prod_t               sum_q;
	prod_t               carry_q;
	logic [2*XLEN-1:0]   product;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			sum_q     <= '0;
			carry_q   <= '0;
		end else begin
			out_valid <= in_valid & ~flush;
			sum_q     <= sum;   // zeros from the tree while stage one is empty.
			carry_q   <= carry;
		end
	end

	// bits above 127 carry only sign extension.
	assign product   = sum_q[2*XLEN-1:0] + carry_q[2*XLEN-1:0];
	assign result_hi = product[2*XLEN-1:XLEN];
	assign result_lo = product[XLEN-1:0];

	// each result is offered for a single cycle.
	a_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid |=> !out_valid
	) else $error("out_valid held for two cycles.");

endmodule

`default_nettype wire

//--- rtl/mul_top.sv
// Pipelined radix-4 Booth multiplier, 64 x 64 bits to a 128-bit product.
`timescale 1ns/1ps
`default_nettype none

module mul_top
	import mul_types_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       flush,
	input  logic       mul_valid,
	input  logic       mulw,
	input  logic [1:0] mul_signed,
	input  xlen_t      multiplicand,
	input  xlen_t      multiplier,
	output logic       mul_ready,
	output logic       out_valid,
	output xlen_t      result_hi,
	output xlen_t      result_lo
);

	mul_issue_if issue ();

	row_array_t rows;
	logic       stage1_valid;
	logic       stage2_valid;
	prod_t      sum;
	prod_t      carry;

	assign issue.valid         = mul_valid;
	assign issue.mulw          = mulw;
	assign issue.sign.a_signed = mul_signed[0];
	assign issue.sign.b_signed = mul_signed[1];
	assign issue.multiplicand  = multiplicand;
	assign issue.multiplier    = multiplier;
	assign mul_ready           = issue.ready;
	assign out_valid           = stage2_valid;

	mul_booth_stage i_booth (
		.clk          (clk),
		.arst_n       (arst_n),
		.flush        (flush),
		.issue        (issue.dst),
		.stage2_valid (stage2_valid),
		.rows         (rows),
		.stage1_valid (stage1_valid)
	);

	mul_csa_tree i_tree (
		.rows     (rows),
		.in_valid (stage1_valid),
		.sum      (sum),
		.carry    (carry)
	);

	mul_result_stage i_result (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.in_valid  (stage1_valid),
		.sum       (sum),
		.carry     (carry),
		.out_valid (stage2_valid),
		.result_hi (result_hi),
		.result_lo (result_lo)
	);

endmodule

`default_nettype wire

//--- rtl/mul_types_pkg.sv
// Multiplier types: operands, extended operands, product rows and the sign mode.
`default_nettype none

package mul_types_pkg;

	import mul_cfg_pkg::*;

	// operand, or one half of the result.
	typedef logic [XLEN-1:0] xlen_t;

	// operand after sign or zero extension.
	typedef logic [OPND_W-1:0] opnd_t;

	// one partial product row, also the tree sum and carry.
	typedef logic [PROD_W-1:0] prod_t;

	// partial products held in stage one, negation row last.
	typedef prod_t row_array_t [N_ROWS];

	// bit 0 is the multiplicand, bit 1 the multiplier.
	typedef struct packed {
		logic b_signed;
		logic a_signed;
	} sign_mode_t;

endpackage

`default_nettype wire

//--- tb/tb_mul_checks.svh
// Multiplier testbench model: operand widening, expected product and compare tasks.
`ifndef TB_MUL_CHECKS_SVH
`define TB_MUL_CHECKS_SVH

typedef logic [2*XLEN-1:0] product_t;

// word mode keeps bits 31:0, the upper bits copy the sign only when signed.
function automatic product_t widen_operand(input xlen_t value, input logic word,
		input logic is_signed);
	product_t wide;
	if (word)
		wide = {{(2*XLEN-WORD_W){is_signed & value[WORD_W-1]}}, value[WORD_W-1:0]};
	else
		wide = {{XLEN{is_signed & value[XLEN-1]}}, value};
	return wide;
endfunction

// low 128 bits of the product of the widened operands.
function automatic product_t model_product(input xlen_t a, input xlen_t b, input logic word,
		input logic [1:0] mode);
	product_t wa;
	product_t wb;
	wa = widen_operand(a, word, mode[0]);
	wb = widen_operand(b, word, mode[1]);
	return wa * wb;
endfunction

task automatic check_result(input string name, input xlen_t got, input xlen_t expected);
	n_checks++;
	if (got !== expected) begin
		n_errors++;
		$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
	n_checks++;
	if (got !== expected) begin
		n_errors++;
		$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
	end
endtask

task automatic compare_product(input product_t expected);
	check_result("result_hi", result_hi, expected[2*XLEN-1:XLEN]);
	check_result("result_lo", result_lo, expected[XLEN-1:0]);
endtask

`endif

//--- tb/tb_mul.sv
// Multiplier testbench: random and directed operations checked against a reference model.
`timescale 1ns/1ps
`default_nettype none

module tb_mul
	import mul_cfg_pkg::*, mul_types_pkg::*;
();

	localparam int TIMEOUT  = 20;  // cycles any single wait may take.
	localparam int N_RANDOM = 200;

	logic       clk;
	logic       arst_n;
	logic       flush;
	logic       mul_valid;
	logic       mulw;
	logic [1:0] mul_signed;
	xlen_t      multiplicand;
	xlen_t      multiplier;
	logic       mul_ready;
	logic       out_valid;
	xlen_t      result_hi;
	xlen_t      result_lo;

	int n_checks;
	int n_errors;
	int test_errors;

	`include "tb_mul_checks.svh"

	product_t pending_q [$]; // products of accepted operations not yet seen.

	mul_top i_dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.flush        (flush),
		.mul_valid    (mul_valid),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic xlen_t random_word();
		return {$urandom(), $urandom()};
	endfunction

	function automatic logic [1:0] random_mode();
		logic [31:0] r;
		r = $urandom();
		return r[1:0];
	endfunction

	task automatic end_test(input int num, input string name);
		$display("test %0d, %s: %s, %0d errors", num, name,
			(n_errors == test_errors) ? "ok" : "mismatch", n_errors - test_errors);
		test_errors = n_errors;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!mul_ready && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!mul_ready) begin
			n_errors++;
			$display("timeout: mul_ready stayed low for %0d cycles", TIMEOUT);
		end
	endtask

	task automatic drive_op(input xlen_t a, input xlen_t b, input logic word,
			input logic [1:0] mode);
		mul_valid    = 1'b1;
		mulw         = word;
		mul_signed   = mode;
		multiplicand = a;
		multiplier   = b;
	endtask

	task automatic run_op(input xlen_t a, input xlen_t b, input logic word,
			input logic [1:0] mode);
		int cycles;
		wait_ready();
		drive_op(a, b, word, mode);
		@(negedge clk); // taken on the edge just passed.
		mul_valid    = 1'b0;
		multiplicand = random_word();
		multiplier   = random_word();
		check_flag("mul_ready", mul_ready, 1'b0);
		cycles = 1;
		while (!out_valid && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!out_valid) begin
			n_errors++;
			$display("timeout: no out_valid within %0d cycles of acceptance", TIMEOUT);
		end else begin
			if (cycles != 2) begin
				n_errors++;
				$display("out_valid rose %0d cycles after acceptance instead of 2", cycles);
			end
			compare_product(model_product(a, b, word, mode));
			check_flag("mul_ready", mul_ready, 1'b0);
			@(negedge clk);
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("mul_ready", mul_ready, 1'b1);
		end
	endtask

	task automatic flush_op();
		wait_ready();
		drive_op(random_word(), random_word(), 1'b0, random_mode());
		@(negedge clk);
		mul_valid = 1'b0;
		flush     = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int i = 0; i < 5; i++) begin
			check_flag("out_valid", out_valid, 1'b0);
			@(negedge clk);
		end
		wait_ready();
		run_op(random_word(), random_word(), 1'b0, random_mode());
	endtask

	task automatic collect_result();
		if (out_valid) begin
			if (pending_q.size() == 0) begin
				n_errors++;
				$display("out_valid pulsed with no operation accepted at %0t", $time);
			end else
				compare_product(pending_q.pop_front());
		end
	endtask

	// mul_valid stays high, a new operation every cycle, only accepted ones count.
	task automatic stream_ops();
		xlen_t      a;
		xlen_t      b;
		logic       word;
		logic [1:0] mode;
		int         accepted;
		int         cycles;
		accepted = 0;
		wait_ready();
		for (int i = 0; i < 40; i++) begin
			a    = random_word();
			b    = random_word();
			word = random_mode() == 2'b00;
			mode = random_mode();
			drive_op(a, b, word, mode);
			if (mul_ready) begin
				pending_q.push_back(model_product(a, b, word, mode));
				accepted++;
			end
			@(negedge clk);
			collect_result();
		end
		mul_valid = 1'b0;
		cycles = 0;
		while (pending_q.size() > 0 && cycles < TIMEOUT) begin
			@(negedge clk);
			collect_result();
			cycles++;
		end
		if (pending_q.size() > 0) begin
			n_errors++;
			$display("timeout: %0d accepted operations gave no out_valid", pending_q.size());
		end
		if (accepted == 0) begin
			n_errors++;
			$display("no operation was accepted while mul_valid was held high");
		end
	endtask

	initial begin
		xlen_t      corners [4];
		logic [1:0] mode;
		void'($urandom(17316));
		n_checks     = 0;
		n_errors     = 0;
		test_errors  = 0;
		arst_n       = 1'b0;
		flush        = 1'b0;
		mul_valid    = 1'b0;
		mulw         = 1'b0;
		mul_signed   = 2'b00;
		multiplicand = '0;
		multiplier   = '0;
		corners = '{'0, '1, {1'b1, {(XLEN-1){1'b0}}}, xlen_t'(1)};
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		check_flag("mul_ready", mul_ready, 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		end_test(1, "reset state");

		for (int i = 0; i < N_RANDOM; i++)
			run_op(random_word(), random_word(), 1'b0, random_mode());
		end_test(2, "full-width random");

		for (int i = 0; i < N_RANDOM; i++)
			run_op(random_word(), random_word(), 1'b1, random_mode()); // upper bits are noise.
		end_test(3, "word-mode random");

		for (int m = 0; m < 4; m++) begin
			mode = m[1:0];
			for (int w = 0; w < 2; w++)
				for (int i = 0; i < 4; i++)
					for (int j = 0; j < 4; j++)
						run_op(corners[i], corners[j], w[0], mode);
		end
		end_test(4, "corner operands");

		repeat (5) flush_op();
		end_test(5, "flush");

		stream_ops();
		end_test(6, "held mul_valid");

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
